// File: sources.f
design/mips_pkg.sv
design/alu.sv
design/regfile.sv
design/control_unit.sv
design/hazard_controller.sv
design/datapath.sv
design/mips_core.sv
tests/mips_core_properties.sv
tests/tb_mips_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_core -Mdir obj_dir -f sources.f

./obj_dir/Vtb_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

// File: tests/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int prog_len   = 48;                     // Program words with the halt
    localparam int halt_index = prog_len - 1;           // j to itself lives here
    localparam int max_cycles = prog_len * 4 + 50;

    logic                                clock;
    logic                                arst_n;
    logic [mips_pkg::data_width-1:0]     instruction, pc, dmem_rd, alu_out, dmem_wd, dbg_rd;
    logic                                dmem_we;
    logic [mips_pkg::reg_addr_width-1:0] dbg_ra;

    logic [mips_pkg::data_width-1:0] imem [64];
    logic [mips_pkg::data_width-1:0] dmem [64];
    logic [mips_pkg::data_width-1:0] model_regs [32];   // Architectural state
    logic [mips_pkg::data_width-1:0] model_mem [64];
    logic [mips_pkg::data_width-1:0] exp_addr [$];      // Stores in program order
    logic [mips_pkg::data_width-1:0] exp_data [$];
    integer seed = 32'h8722;
    int     store_idx = 0;
    int     cycle_count = 0;
    logic   halt_seen = 1'b0;

    mips_core u_mips_core (
        .clock (clock), .arst_n (arst_n),
        .instruction (instruction), .pc (pc),
        .dmem_rd (dmem_rd), .dmem_we (dmem_we), .alu_out (alu_out), .dmem_wd (dmem_wd),
        .dbg_ra (dbg_ra), .dbg_rd (dbg_rd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////////////////////

    assign instruction = imem[pc[7:2]];                 // Async fetch
    assign dmem_rd     = dmem[alu_out[7:2]];            // Async load

    always @(posedge clock) begin
        if (dmem_we) dmem[alu_out[7:2]] <= dmem_wd;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program generator and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(8));                       // r0..r7 keeps hazards frequent
    endfunction

    function automatic logic [15:0] rand_offset();
        return 16'(rand_below(64) * 4);                 // Word aligned, below 256
    endfunction

    function automatic mips_pkg::funct_e rand_funct();
        case (rand_below(5))
            0:       return mips_pkg::fn_add;
            1:       return mips_pkg::fn_sub;
            2:       return mips_pkg::fn_and;
            3:       return mips_pkg::fn_or;
            default: return mips_pkg::fn_slt;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input mips_pkg::funct_e fn,
                                          input logic [4:0] rd, rs, rt);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input mips_pkg::opcode_e op,
                                          input logic [4:0] rt, rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] make_beq(input int slot, input logic [4:0] rs);
        int         max_off;
        logic [4:0] rt;
        max_off = (halt_index - slot - 1 < 3) ? halt_index - slot - 1 : 3;  // Stay before halt
        rt = (rand_below(2) == 0) ? rs : rand_reg();    // Equal regs give a taken branch
        return enc_i(mips_pkg::op_beq, rt, rs, 16'(1 + rand_below(max_off)));
    endfunction

    function automatic logic [31:0] gen_any(input int slot);
        int kind;
        kind = rand_below(10);
        if (kind >= 8 && slot < halt_index - 1) return make_beq(slot, rand_reg());
        if (kind == 7) return enc_i(mips_pkg::op_sw, rand_reg(), 5'd0, rand_offset());
        if (kind == 6) return enc_i(mips_pkg::op_lw, rand_reg(), 5'd0, rand_offset());
        if (kind >= 4) return enc_i(mips_pkg::op_addi, rand_reg(), rand_reg(),
                                    16'(rand_below(65536)));
        return enc_r(rand_funct(), rand_reg(), rand_reg(), rand_reg());
    endfunction

    // Producer and consumer kinds rotate so all twelve combinations appear
    task automatic gen_pair(input int slot, input int pair);
        logic [4:0] x;
        x = 5'(1 + rand_below(7));                      // Never r0
        case (pair % 3)
            0:       imem[slot] = enc_i(mips_pkg::op_lw, x, 5'd0, rand_offset());
            1:       imem[slot] = enc_i(mips_pkg::op_addi, x, rand_reg(), 16'(rand_below(65536)));
            default: imem[slot] = enc_r(rand_funct(), x, rand_reg(), rand_reg());
        endcase
        case (pair % 4)
            0:       imem[slot+1] = enc_r(rand_funct(), rand_reg(), x, rand_reg());
            1:       imem[slot+1] = enc_i(mips_pkg::op_sw, x, 5'd0, rand_offset());
            2:       imem[slot+1] = make_beq(slot + 1, x);  // Operand made just before
            default: imem[slot+1] = enc_i(mips_pkg::op_addi, rand_reg(), x, 16'(rand_below(256)));
        endcase
    endtask

    task automatic build_program();
        int slot;
        slot = 0;
        while (slot < halt_index) begin
            if (slot % 4 == 0 && slot + 1 < halt_index) begin
                gen_pair(slot, slot / 4);
                slot += 2;
            end else begin
                imem[slot] = gen_any(slot);
                slot += 1;
            end
        end
        imem[halt_index] = {mips_pkg::op_j, 26'(halt_index)};
        for (int k = prog_len; k < 64; k++) begin   // Dead code past the halt
            imem[k] = enc_i(mips_pkg::op_addi, 5'(k % 7 + 1), 5'd0, 16'h7abc);
        end
        for (int k = 0; k < 64; k++) begin
            dmem[k]      = 32'h1357_0000 ^ (32'(k) * 32'h0002_0005);
            model_mem[k] = dmem[k];
        end
    endtask

    function automatic logic [31:0] model_alu(input mips_pkg::funct_e fn,
                                              input logic [31:0] a, b);
        case (fn)
            mips_pkg::fn_sub: return a - b;
            mips_pkg::fn_and: return a & b;
            mips_pkg::fn_or:  return a | b;
            mips_pkg::fn_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return a + b;
        endcase
    endfunction

    function automatic void write_reg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) model_regs[r] = v;              // r0 stays zero
    endfunction

    // One instruction at a time, in program order
    task automatic run_model();
        int                mpc;
        logic              done;
        logic [31:0]       ins, a, b, imm, addr;
        mips_pkg::opcode_e op;
        mpc  = 0;
        done = 1'b0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        while (!done && mpc < prog_len) begin
            ins  = imem[mpc];
            op   = mips_pkg::opcode_e'(ins[31:26]);
            a    = model_regs[ins[25:21]];
            b    = model_regs[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            mpc  = mpc + 1;
            case (op)
                mips_pkg::op_rtype: write_reg(ins[15:11],
                                              model_alu(mips_pkg::funct_e'(ins[5:0]), a, b));
                mips_pkg::op_addi:  write_reg(ins[20:16], a + imm);
                mips_pkg::op_lw:    write_reg(ins[20:16], model_mem[addr[7:2]]);
                mips_pkg::op_sw: begin
                    model_mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                mips_pkg::op_beq: if (a == b) mpc = mpc + int'(imm);  // No delay slot
                mips_pkg::op_j: begin
                    done = (int'(ins[25:0]) == mpc - 1);   // Jump to itself
                    mpc  = int'(ins[25:0]);
                end
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s expected %h got %h", $time, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    always @(negedge clock) begin                       // Store sampled mid-cycle
        if (arst_n && dmem_we) begin
            if (store_idx < exp_addr.size()) begin
                check_value(alu_out, exp_addr[store_idx], $sformatf("store %0d addr", store_idx));
                check_value(dmem_wd, exp_data[store_idx], $sformatf("store %0d data", store_idx));
            end else begin
                check_value(32'(store_idx), 32'(exp_addr.size()), "store beyond model count");
            end
            store_idx++;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            if (halt_seen) $display("Timeout: run went past %0d cycles", max_cycles);
            else $display("Timeout: halt PC never reached in %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        dbg_ra = '0;
        build_program();
        run_model();
        @(posedge clock);
        @(negedge clock);
        check_value(pc, '0, "pc in reset");
        check_value(32'(dmem_we), '0, "dmem_we in reset");
        @(posedge clock);
        arst_n <= 1'b1;                                 // Two edges held low
        while (pc != 32'(halt_index * 4)) @(negedge clock);
        halt_seen = 1'b1;
        repeat (8) @(negedge clock);                    // Drain the pipeline
        for (int r = 0; r < 32; r++) begin
            @(posedge clock);
            dbg_ra <= 5'(r);
            @(negedge clock);
            check_value(dbg_rd, model_regs[r], $sformatf("register r%0d", r));
        end
        check_value(32'(store_idx), 32'(exp_addr.size()), "number of stores");
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tests/mips_core_properties.sv
`timescale 1ns/1ps

module mips_core_properties (
    input logic                                clock,
    input logic                                arst_n,
    input logic                                stall,
    input logic                                dmem_we,
    input logic [mips_pkg::reg_addr_width-1:0] e_rs,
    input logic [mips_pkg::reg_addr_width-1:0] e_rt,
    input logic [mips_pkg::data_width-1:0]     e_a,
    input logic [mips_pkg::data_width-1:0]     e_b_reg
);

    // Register 0 reaches the ALU as zero, whatever the forwarding muxes pick
    r0_zero_a: assert property (@(posedge clock) disable iff (!arst_n)
        (e_rs == '0) |-> (e_a == '0))
        else $error("register 0 reached ALU operand a as nonzero");

    r0_zero_b: assert property (@(posedge clock) disable iff (!arst_n)
        (e_rt == '0) |-> (e_b_reg == '0))              // Also the store data
        else $error("register 0 reached ALU operand b as nonzero");

    stall_max_two: assert property (@(posedge clock) disable iff (!arst_n)
        (stall && $past(stall)) |=> !stall)             // Load then beq is the longest
        else $error("stall held for more than two cycles");

    no_store_on_release: assert property (@(posedge clock)
        $rose(arst_n) |-> !dmem_we)
        else $error("data memory write right after reset release");

endmodule

bind datapath mips_core_properties u_mips_core_properties (
    .clock (clock), .arst_n (arst_n), .stall (stall), .dmem_we (dmem_we),
    .e_rs (e_rs), .e_rt (e_rt), .e_a (e_a), .e_b_reg (e_b_reg)
);

// File: design/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic [mips_pkg::data_width-1:0]     instruction,
    output logic [mips_pkg::data_width-1:0]     pc,
    input  logic [mips_pkg::data_width-1:0]     dmem_rd,
    output logic                                dmem_we,
    output logic [mips_pkg::data_width-1:0]     alu_out,
    output logic [mips_pkg::data_width-1:0]     dmem_wd,
    input  logic [mips_pkg::reg_addr_width-1:0] dbg_ra,
    output logic [mips_pkg::data_width-1:0]     dbg_rd
);

    logic [mips_pkg::data_width-1:0] d_instruction;     // Decode-stage word to the decoder
    mips_pkg::alu_op_e               d_alu_op;
    mips_pkg::sel_result_e           d_sel_result;
    logic                            d_alu_src_imm, d_rf_we, d_sel_wa_rd;
    logic                            d_dmem_we, d_is_beq, d_is_j;

    control_unit u_control_unit (
        .d_instruction (d_instruction),
        .alu_op        (d_alu_op),
        .alu_src_imm   (d_alu_src_imm),
        .rf_we         (d_rf_we),
        .sel_wa_rd     (d_sel_wa_rd),
        .sel_result    (d_sel_result),
        .dmem_we       (d_dmem_we),
        .is_beq        (d_is_beq),
        .is_j          (d_is_j)
    );

    datapath u_datapath (
        .clock         (clock),
        .arst_n        (arst_n),
        .instruction   (instruction),
        .dmem_rd       (dmem_rd),
        .pc            (pc),
        .alu_out       (alu_out),
        .dmem_wd       (dmem_wd),
        .dmem_we       (dmem_we),
        .d_instruction (d_instruction),
        .d_alu_op      (d_alu_op),
        .d_alu_src_imm (d_alu_src_imm),
        .d_rf_we       (d_rf_we),
        .d_sel_wa_rd   (d_sel_wa_rd),
        .d_sel_result  (d_sel_result),
        .d_dmem_we     (d_dmem_we),
        .d_is_beq      (d_is_beq),
        .d_is_j        (d_is_j),
        .dbg_ra        (dbg_ra),
        .dbg_rd        (dbg_rd)
    );

endmodule

// File: design/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic [mips_pkg::data_width-1:0]     instruction,
    input  logic [mips_pkg::data_width-1:0]     dmem_rd,
    output logic [mips_pkg::data_width-1:0]     pc,
    output logic [mips_pkg::data_width-1:0]     alu_out,
    output logic [mips_pkg::data_width-1:0]     dmem_wd,
    output logic                                dmem_we,
    output logic [mips_pkg::data_width-1:0]     d_instruction,  // Control unit decodes this
    input  mips_pkg::alu_op_e                   d_alu_op,
    input  logic                                d_alu_src_imm,
    input  logic                                d_rf_we,
    input  logic                                d_sel_wa_rd,
    input  mips_pkg::sel_result_e               d_sel_result,
    input  logic                                d_dmem_we,
    input  logic                                d_is_beq,
    input  logic                                d_is_j,
    input  logic [mips_pkg::reg_addr_width-1:0] dbg_ra,
    output logic [mips_pkg::data_width-1:0]     dbg_rd
);

    logic [mips_pkg::data_width-1:0]     f_pc, f_pc_plus4, f_jump_target, f_pc_next;
    logic                                f_is_j;
    mips_pkg::sel_pc_e                   sel_pc;
    logic [mips_pkg::data_width-1:0]     d_pc_plus4, d_imm, d_rd0, d_rd1;
    logic [mips_pkg::data_width-1:0]     d_cmp_a, d_cmp_b, d_branch_target;
    logic [mips_pkg::reg_addr_width-1:0] d_rs, d_rt, d_rd, d_wa;
    logic                                d_taken;
    mips_pkg::alu_op_e                   e_alu_op;
    mips_pkg::sel_result_e               e_sel_result;
    logic                                e_alu_src_imm, e_rf_we, e_dmem_we, e_is_load, e_bubble;
    logic [mips_pkg::reg_addr_width-1:0] e_rs, e_rt, e_wa;
    logic [mips_pkg::data_width-1:0]     e_rd0, e_rd1, e_imm, e_a, e_b_reg, e_b, e_y;
    mips_pkg::sel_result_e               m_sel_result;
    logic                                m_rf_we, m_is_load;
    logic [mips_pkg::reg_addr_width-1:0] m_wa;
    logic [mips_pkg::data_width-1:0]     m_alu_out;
    mips_pkg::sel_result_e               w_sel_result;
    logic                                w_rf_we;
    logic [mips_pkg::reg_addr_width-1:0] w_wa;
    logic [mips_pkg::data_width-1:0]     w_alu_out, w_dmem_rd, w_result;
    mips_pkg::sel_fwd_e                  fwd_a, fwd_b;
    logic                                stall, flush_e;

    function automatic logic [mips_pkg::data_width-1:0] fwd_mux(
        input mips_pkg::sel_fwd_e              sel,
        input logic [mips_pkg::data_width-1:0] rf_val,
        input logic [mips_pkg::data_width-1:0] mem_val,
        input logic [mips_pkg::data_width-1:0] wb_val
    );
        case (sel)
            mips_pkg::fwd_mem: return mem_val;
            mips_pkg::fwd_wb:  return wb_val;
            default:           return rf_val;
        endcase
    endfunction

    hazard_controller u_hazard_controller (
        .d_rs (d_rs), .d_rt (d_rt), .d_is_beq (d_is_beq),
        .e_rs (e_rs), .e_rt (e_rt), .e_wa (e_wa), .e_rf_we (e_rf_we), .e_is_load (e_is_load),
        .m_wa (m_wa), .m_rf_we (m_rf_we), .m_is_load (m_is_load),
        .w_wa (w_wa), .w_rf_we (w_rf_we),
        .fwd_a (fwd_a), .fwd_b (fwd_b), .stall (stall), .flush_e (flush_e)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    assign f_pc_plus4    = f_pc + 32'd4;
    assign f_is_j        = mips_pkg::opcode_e'(instruction[31:26]) == mips_pkg::op_j;
    assign f_jump_target = {f_pc_plus4[31:28], instruction[25:0], 2'b00};

    always_comb begin
        if (d_taken) sel_pc = mips_pkg::pc_branch;      // Older instruction wins
        else if (f_is_j) sel_pc = mips_pkg::pc_jump;
        else sel_pc = mips_pkg::pc_plus4;
        case (sel_pc)
            mips_pkg::pc_branch: f_pc_next = d_branch_target;
            mips_pkg::pc_jump:   f_pc_next = f_jump_target;
            default:             f_pc_next = f_pc_plus4;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) f_pc <= '0;
        else if (!stall) f_pc <= f_pc_next;             // Held on any stall
    end

    assign pc = f_pc;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) d_instruction <= '0;               // All-zero word decodes as bubble
        else if (d_taken) d_instruction <= '0;          // Squash fall-through
        else if (!stall) d_instruction <= instruction;
    end

    always_ff @(posedge clock) begin
        if (!stall) d_pc_plus4 <= f_pc_plus4;
    end

    assign d_rs  = d_instruction[25:21];
    assign d_rt  = d_instruction[20:16];
    assign d_rd  = d_instruction[15:11];
    assign d_wa  = d_sel_wa_rd ? d_rd : d_rt;           // R-type vs I-type dest
    assign d_imm = {{16{d_instruction[15]}}, d_instruction[15:0]};

    regfile u_regfile (
        .clock (clock), .arst_n (arst_n),
        .we    (w_rf_we), .wa (w_wa), .wd (w_result),
        .ra0   (d_rs), .ra1 (d_rt), .ra2 (dbg_ra),
        .rd0   (d_rd0), .rd1 (d_rd1), .rd2 (dbg_rd)
    );

    // Memory-stage ALU result feeds the compare; writeback comes through the regfile
    assign d_cmp_a = (m_rf_we && d_rs != '0 && m_wa == d_rs) ? m_alu_out : d_rd0;
    assign d_cmp_b = (m_rf_we && d_rt != '0 && m_wa == d_rt) ? m_alu_out : d_rd1;
    assign d_taken = d_is_beq && !stall && (d_cmp_a == d_cmp_b);
    assign d_branch_target = d_pc_plus4 + {d_imm[29:0], 2'b00};

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    assign e_bubble = flush_e || d_is_j;                // j already redirected in fetch

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            e_rf_we      <= 1'b0;
            e_dmem_we    <= 1'b0;
            e_sel_result <= mips_pkg::res_alu;
        end else begin
            e_rf_we      <= d_rf_we && !e_bubble;
            e_dmem_we    <= d_dmem_we && !e_bubble;
            e_sel_result <= e_bubble ? mips_pkg::res_alu : d_sel_result;
        end
    end

    always_ff @(posedge clock) begin
        e_alu_op      <= d_alu_op;
        e_alu_src_imm <= d_alu_src_imm;
        e_rs          <= d_rs;
        e_rt          <= d_rt;
        e_wa          <= d_wa;
        e_rd0         <= d_rd0;
        e_rd1         <= d_rd1;
        e_imm         <= d_imm;
    end

    assign e_is_load = e_sel_result == mips_pkg::res_mem;
    assign e_a       = fwd_mux(fwd_a, e_rd0, m_alu_out, w_result);
    assign e_b_reg   = fwd_mux(fwd_b, e_rd1, m_alu_out, w_result);  // Also store data
    assign e_b       = e_alu_src_imm ? e_imm : e_b_reg;

    alu u_alu (.a (e_a), .b (e_b), .op (e_alu_op), .y (e_y), .zero ());

    ////////////////////////////////////////////////////////////////////////////
    // Memory
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            m_rf_we      <= 1'b0;
            dmem_we      <= 1'b0;
            m_sel_result <= mips_pkg::res_alu;
        end else begin
            m_rf_we      <= e_rf_we;
            dmem_we      <= e_dmem_we;
            m_sel_result <= e_sel_result;
        end
    end

    always_ff @(posedge clock) begin
        m_alu_out <= e_y;
        dmem_wd   <= e_b_reg;
        m_wa      <= e_wa;
    end

    assign m_is_load = m_sel_result == mips_pkg::res_mem;
    assign alu_out   = m_alu_out;                       // Data memory address

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            w_rf_we      <= 1'b0;
            w_sel_result <= mips_pkg::res_alu;
        end else begin
            w_rf_we      <= m_rf_we;
            w_sel_result <= m_sel_result;
        end
    end

    always_ff @(posedge clock) begin
        w_alu_out <= m_alu_out;
        w_dmem_rd <= dmem_rd;                           // Async read captured here
        w_wa      <= m_wa;
    end

    assign w_result = (w_sel_result == mips_pkg::res_mem) ? w_dmem_rd : w_alu_out;

endmodule

// File: design/hazard_controller.sv
`timescale 1ns/1ps

module hazard_controller (
    input  logic [mips_pkg::reg_addr_width-1:0] d_rs,
    input  logic [mips_pkg::reg_addr_width-1:0] d_rt,
    input  logic                                d_is_beq,
    input  logic [mips_pkg::reg_addr_width-1:0] e_rs,
    input  logic [mips_pkg::reg_addr_width-1:0] e_rt,
    input  logic [mips_pkg::reg_addr_width-1:0] e_wa,
    input  logic                                e_rf_we,
    input  logic                                e_is_load,
    input  logic [mips_pkg::reg_addr_width-1:0] m_wa,
    input  logic                                m_rf_we,
    input  logic                                m_is_load,
    input  logic [mips_pkg::reg_addr_width-1:0] w_wa,
    input  logic                                w_rf_we,
    output mips_pkg::sel_fwd_e                  fwd_a,
    output mips_pkg::sel_fwd_e                  fwd_b,
    output logic                                stall,
    output logic                                flush_e
);

    logic e_hits_d;                                     // Execute dest is a decode source
    logic m_hits_d;                                     // Memory dest is a decode source
    logic load_use;
    logic beq_wait;

    function automatic mips_pkg::sel_fwd_e pick_fwd(
        input logic [mips_pkg::reg_addr_width-1:0] src
    );
        if (src == '0) return mips_pkg::fwd_none;       // r0 never forwarded
        if (m_rf_we && m_wa == src) return mips_pkg::fwd_mem;   // Newest value wins
        if (w_rf_we && w_wa == src) return mips_pkg::fwd_wb;
        return mips_pkg::fwd_none;
    endfunction

    always_comb begin
        fwd_a = pick_fwd(e_rs);
        fwd_b = pick_fwd(e_rt);
    end

    assign e_hits_d = (e_wa != '0) && (e_wa == d_rs || e_wa == d_rt);
    assign m_hits_d = (m_wa != '0) && (m_wa == d_rs || m_wa == d_rt);

    assign load_use = e_is_load && e_hits_d;            // Data only ready after memory
    // Compare in decode needs final values; memory ALU results are forwarded there
    assign beq_wait = d_is_beq && ((e_rf_we && e_hits_d) || (m_is_load && m_hits_d));

    assign stall   = load_use || beq_wait;              // Hold fetch and decode
    assign flush_e = stall;                             // Bubble into execute

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic [mips_pkg::data_width-1:0] d_instruction,
    output mips_pkg::alu_op_e               alu_op,
    output logic                            alu_src_imm,
    output logic                            rf_we,
    output logic                            sel_wa_rd,
    output mips_pkg::sel_result_e           sel_result,
    output logic                            dmem_we,
    output logic                            is_beq,
    output logic                            is_j
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;

    assign opcode = mips_pkg::opcode_e'(d_instruction[31:26]);
    assign funct  = mips_pkg::funct_e'(d_instruction[5:0]);

    always_comb begin
        // Defaults form a bubble
        alu_op      = mips_pkg::alu_add;
        alu_src_imm = 1'b0;
        rf_we       = 1'b0;
        sel_wa_rd   = 1'b0;
        sel_result  = mips_pkg::res_alu;
        dmem_we     = 1'b0;
        is_beq      = 1'b0;
        is_j        = 1'b0;

        case (opcode)
            mips_pkg::op_rtype: begin
                rf_we     = 1'b1;
                sel_wa_rd = 1'b1;                       // Destination in rd
                case (funct)
                    mips_pkg::fn_add: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
                    default:          rf_we  = 1'b0;    // Unknown funct, also all-zero word
                endcase
            end
            mips_pkg::op_addi: begin
                rf_we       = 1'b1;
                alu_src_imm = 1'b1;
            end
            mips_pkg::op_lw: begin
                rf_we       = 1'b1;
                alu_src_imm = 1'b1;                     // Address is base + offset
                sel_result  = mips_pkg::res_mem;
            end
            mips_pkg::op_sw: begin
                dmem_we     = 1'b1;
                alu_src_imm = 1'b1;
            end
            mips_pkg::op_beq: is_beq = 1'b1;            // Compare done in datapath
            mips_pkg::op_j:   is_j   = 1'b1;
            default: ;                                  // Unknown opcode stays a bubble
        endcase
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                we,
    input  logic [mips_pkg::reg_addr_width-1:0] wa,
    input  logic [mips_pkg::data_width-1:0]     wd,
    input  logic [mips_pkg::reg_addr_width-1:0] ra0,
    input  logic [mips_pkg::reg_addr_width-1:0] ra1,
    input  logic [mips_pkg::reg_addr_width-1:0] ra2,
    output logic [mips_pkg::data_width-1:0]     rd0,
    output logic [mips_pkg::data_width-1:0]     rd1,
    output logic [mips_pkg::data_width-1:0]     rd2
);

    logic [mips_pkg::data_width-1:0] regs [31:1];       // r0 has no storage

    function automatic logic [mips_pkg::data_width-1:0] read_port(
        input logic [mips_pkg::reg_addr_width-1:0] ra
    );
        if (ra == '0) return '0;                        // r0 reads zero
        if (we && wa == ra) return wd;                  // Write-through to decode
        return regs[ra];
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin              // Writes to r0 dropped
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd0 = read_port(ra0);                           // rs
        rd1 = read_port(ra1);                           // rt
        rd2 = read_port(ra2);                           // Debug
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [mips_pkg::data_width-1:0] a,
    input  logic [mips_pkg::data_width-1:0] b,
    input  mips_pkg::alu_op_e               op,
    output logic [mips_pkg::data_width-1:0] y,
    output logic                            zero
);

    logic slt_bit;                                      // Signed a < b

    assign slt_bit = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::alu_add: y = a + b;
            mips_pkg::alu_sub: y = a - b;
            mips_pkg::alu_and: y = a & b;
            mips_pkg::alu_or:  y = a | b;
            mips_pkg::alu_slt: y = {{(mips_pkg::data_width-1){1'b0}}, slt_bit};
            default:           y = '0;                  // Unused encodings
        endcase
    end

    assign zero = (y == '0);                            // Visible in waves only

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

    localparam int data_width     = 32;                 // Word width
    localparam int reg_addr_width = 5;                  // 32 architectural registers

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt                                         // Signed compare
    } alu_op_e;

    typedef enum logic [1:0] {
        pc_plus4,                                       // Sequential
        pc_branch,                                      // Taken beq from decode
        pc_jump                                         // j seen in fetch
    } sel_pc_e;

    typedef enum logic {
        res_alu,
        res_mem                                         // Load data
    } sel_result_e;

    typedef enum logic [1:0] {
        fwd_none,                                       // Register file value
        fwd_mem,                                        // ALU result in memory stage
        fwd_wb                                          // Result in writeback stage
    } sel_fwd_e;

endpackage
